/* source/elink_pkg.sv */
package elink_pkg;

   // Fabric packet width used by the top level
   localparam int PW_DEFAULT = 104;

   // ######################################################################
   // Packet field positions
   // ######################################################################
   localparam int PKT_WRITE_BIT    = 0;
   localparam int PKT_DATAMODE_LSB = 1;
   localparam int PKT_CTRLMODE_LSB = 3;
   localparam int PKT_DSTADDR_LSB  = 8;
   localparam int PKT_DATA_LSB     = 40;
   localparam int PKT_SRCADDR_LSB  = 72;

   // 64-bit write, the only mode that can burst
   localparam logic [1:0] DATAMODE_DOUBLE = 2'd3;

   // Transmit FSM, one state per beat
   typedef enum logic [2:0] {
      IDLE   = 3'b000,
      CYCLE1 = 3'b001,
      CYCLE2 = 3'b010,
      CYCLE3 = 3'b011,
      CYCLE4 = 3'b100,
      CYCLE5 = 3'b101,
      CYCLE6 = 3'b110,
      CYCLE7 = 3'b111
   } etx_state_t;

   // Header view, top bits first
   typedef struct packed {
      logic [15:0] zero_hi;
      logic        write_n;
      logic [6:0]  zero_mid;
      logic [3:0]  ctrlmode;
      logic [31:0] dstaddr;
      logic [1:0]  datamode;
      logic        write;
      logic        access;
   } etx_header_t;

   // Payload view
   typedef struct packed {
      logic [31:0] data;
      logic [31:0] srcaddr;
   } etx_payload_t;

   // One beat word, header first, then reloaded with the payload
   typedef union packed {
      etx_header_t  hdr;
      etx_payload_t pld;
   } etx_beat_word_t;

endpackage

/* source/etx_packet_queue.sv */
`timescale 1ns/1ps

module etx_packet_queue
   import elink_pkg::*;
#(
   parameter int PW    = 104,
   parameter int DEPTH = 4
)
(
   input  logic          tx_lclk,
   input  logic          reset,
   // Fabric write strobe
   input  logic [PW-1:0] tx_packet,
   input  logic          tx_access,
   output logic          tx_full,
   // Head packet toward the transmit FSM
   input  logic          pkt_pop,
   output logic          pkt_valid,
   output logic          pkt_write,
   output logic [1:0]    pkt_datamode,
   output logic [3:0]    pkt_ctrlmode,
   output logic [31:0]   pkt_dstaddr,
   output logic [31:0]   pkt_data,
   output logic [31:0]   pkt_srcaddr,
   output logic          pkt_burst
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   logic [PW-1:0] mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW-1:0] nx_ptr;
   logic [AW:0]   count;
   logic          push;
   logic          pop;
   logic [PW-1:0] head;
   logic [PW-1:0] next;

   // Wrap at DEPTH, which need not be a power of two
   function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
      return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   // ######################################################################
   // Storage and pointers
   // ######################################################################

   // Strobe while full is dropped
   assign tx_full   = (count == (AW + 1)'(DEPTH));
   assign pkt_valid = (count != '0);
   assign push      = tx_access & ~tx_full;
   assign pop       = pkt_pop & pkt_valid;

   always_ff @(posedge tx_lclk)
   begin
      if (push)
      begin
         mem[wr_ptr] <= tx_packet;
      end
   end

   always_ff @(posedge tx_lclk)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
         begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (pop)
         begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         // Simultaneous push and pop leaves the count alone
         if (push && !pop)
         begin
            count <= count + 1'b1;
         end
         else if (pop && !push)
         begin
            count <= count - 1'b1;
         end
      end
   end

   // ######################################################################
   // Head decode and burst check
   // ######################################################################
   assign nx_ptr = ptr_inc(rd_ptr);
   assign head   = mem[rd_ptr];
   assign next   = mem[nx_ptr];

   assign pkt_write    = head[PKT_WRITE_BIT];
   assign pkt_datamode = head[PKT_DATAMODE_LSB +: 2];
   assign pkt_ctrlmode = head[PKT_CTRLMODE_LSB +: 4];
   assign pkt_dstaddr  = head[PKT_DSTADDR_LSB +: 32];
   assign pkt_data     = head[PKT_DATA_LSB +: 32];
   assign pkt_srcaddr  = head[PKT_SRCADDR_LSB +: 32];

   // Second entry continues the head as a double-write burst
   assign pkt_burst = (count >= (AW + 1)'(2))
                    & head[PKT_WRITE_BIT]
                    & next[PKT_WRITE_BIT]
                    & (head[PKT_DATAMODE_LSB +: 2] == DATAMODE_DOUBLE)
                    & (next[PKT_DATAMODE_LSB +: 2] == DATAMODE_DOUBLE)
                    & (next[PKT_CTRLMODE_LSB +: 4] == head[PKT_CTRLMODE_LSB +: 4])
                    & (next[PKT_DSTADDR_LSB +: 32] == head[PKT_DSTADDR_LSB +: 32] + 32'd8);

   // The FSM only pops a packet it has seen
   a_no_pop_empty : assert property (@(posedge tx_lclk) disable iff (reset)
      pkt_pop |-> pkt_valid)
      else $error("etx_packet_queue: pop while empty");

endmodule

/* source/etx_io.sv */
`timescale 1ns/1ps

module etx_io
   import elink_pkg::*;
#(
   parameter int PW = 104
)
(
   input  logic        tx_lclk,
   input  logic        reset,
   // Head packet from the queue
   input  logic        pkt_valid,
   input  logic        pkt_burst,
   input  logic        pkt_write,
   input  logic [1:0]  pkt_datamode,
   input  logic [3:0]  pkt_ctrlmode,
   input  logic [31:0] pkt_dstaddr,
   input  logic [31:0] pkt_data,
   input  logic [31:0] pkt_srcaddr,
   output logic        pkt_pop,
   // Beats toward the double-rate stage
   output logic [15:0] data16,
   output logic        frame,
   output logic        tx_io_wait
);

   etx_state_t     state;
   etx_state_t     state_d1;
   etx_state_t     state_d2;
   logic           burst_q;
   logic [PW-1:0]  pkt_in;
   logic [PW-1:0]  pkt_q;
   etx_beat_word_t beat_word;

   // ######################################################################
   // Transmit FSM
   // ######################################################################
   always_ff @(posedge tx_lclk)
   begin
      if (reset)
      begin
         state <= IDLE;
      end
      else
      begin
         case (state)
            IDLE    : state <= pkt_valid ? CYCLE1 : IDLE;
            CYCLE1  : state <= CYCLE2;
            CYCLE2  : state <= CYCLE3;
            CYCLE3  : state <= CYCLE4;
            CYCLE4  : state <= CYCLE5;
            CYCLE5  : state <= CYCLE6;
            CYCLE6  : state <= CYCLE7;
            // Burst skips the header beats
            CYCLE7  : state <= burst_q ? CYCLE4 : IDLE;
            default : state <= IDLE;
         endcase
      end
   end

   // Take the head on frame start, or the next burst packet
   assign pkt_pop = (state == CYCLE1) | ((state == CYCLE7) & burst_q);

   // Burst flag of the packet just taken, held until its CYCLE7
   always_ff @(posedge tx_lclk)
   begin
      if (reset)
      begin
         burst_q <= 1'b0;
      end
      else if (pkt_pop)
      begin
         burst_q <= pkt_burst;
      end
   end

   // Delayed state copies, frame follows the first one
   always_ff @(posedge tx_lclk)
   begin
      if (reset)
      begin
         state_d1 <= IDLE;
         state_d2 <= IDLE;
         frame    <= 1'b0;
      end
      else
      begin
         state_d1 <= state;
         state_d2 <= state_d1;
         frame    <= (state_d1 != IDLE);
      end
   end

   // Write pushback toward the fabric clock domain
   always_ff @(posedge tx_lclk)
   begin
      if (reset)
      begin
         tx_io_wait <= 1'b0;
      end
      else if ((state == CYCLE4) && !burst_q)
      begin
         tx_io_wait <= 1'b1;
      end
      else if (state == CYCLE7)
      begin
         tx_io_wait <= 1'b0;
      end
   end

   // ######################################################################
   // Packet pipeline
   // ######################################################################

   // Repack the head fields into one packet word
   always_comb
   begin
      pkt_in                              = '0;
      pkt_in[PKT_WRITE_BIT]               = pkt_write;
      pkt_in[PKT_DATAMODE_LSB +: 2]       = pkt_datamode;
      pkt_in[PKT_CTRLMODE_LSB +: 4]       = pkt_ctrlmode;
      pkt_in[PKT_DSTADDR_LSB +: 32]       = pkt_dstaddr;
      pkt_in[PKT_DATA_LSB +: 32]          = pkt_data;
      pkt_in[PKT_SRCADDR_LSB +: 32]       = pkt_srcaddr;
   end

   always_ff @(posedge tx_lclk)
   begin
      if (pkt_pop)
      begin
         pkt_q <= pkt_in;
      end
   end

   // Header view one cycle after CYCLE1, payload one after CYCLE4
   always_ff @(posedge tx_lclk)
   begin
      if (state_d1 == CYCLE1)
      begin
         beat_word.hdr.zero_hi  <= '0;
         beat_word.hdr.write_n  <= ~pkt_q[PKT_WRITE_BIT];
         beat_word.hdr.zero_mid <= '0;
         beat_word.hdr.ctrlmode <= pkt_q[PKT_CTRLMODE_LSB +: 4];
         beat_word.hdr.dstaddr  <= pkt_q[PKT_DSTADDR_LSB +: 32];
         beat_word.hdr.datamode <= pkt_q[PKT_DATAMODE_LSB +: 2];
         beat_word.hdr.write    <= pkt_q[PKT_WRITE_BIT];
         beat_word.hdr.access   <= 1'b1;
      end
      else if (state_d1 == CYCLE4)
      begin
         beat_word.pld.data    <= pkt_q[PKT_DATA_LSB +: 32];
         beat_word.pld.srcaddr <= pkt_q[PKT_SRCADDR_LSB +: 32];
      end
   end

   // ######################################################################
   // Beat selection
   // ######################################################################

   // Lines up with frame, zero between frames
   always_comb
   begin
      case (state_d2)
         CYCLE1  : data16 = beat_word[47:32];
         CYCLE2  : data16 = beat_word[31:16];
         CYCLE3  : data16 = beat_word[15:0];
         CYCLE4  : data16 = beat_word[63:48];
         CYCLE5  : data16 = beat_word[47:32];
         CYCLE6  : data16 = beat_word[31:16];
         CYCLE7  : data16 = beat_word[15:0];
         default : data16 = '0;
      endcase
   end

   // Only a double write may carry the burst flag into the FSM
   a_burst_double : assert property (@(posedge tx_lclk) disable iff (reset)
      (pkt_pop && pkt_burst) |-> (pkt_write && (pkt_datamode == DATAMODE_DOUBLE)))
      else $error("etx_io: burst flag on a packet that is not a double write");

endmodule

/* source/etx_ddr_out.sv */
`timescale 1ns/1ps

module etx_ddr_out
(
   input  logic        tx_lclk,
   input  logic        tx_lclk90,
   input  logic [15:0] data16,
   input  logic        frame,
   // Link pins, true and complement
   output logic [7:0]  txo_data_p,
   output logic [7:0]  txo_data_n,
   output logic        txo_frame_p,
   output logic        txo_frame_n,
   output logic        txo_lclk_p,
   output logic        txo_lclk_n
);

   logic [7:0] data_pin;
   logic       frame_pin;
   logic       lclk_pin;

   // ######################################################################
   // Double-rate muxes
   // ######################################################################

   // Upper byte in the high phase, lower byte in the low phase
   assign data_pin = tx_lclk ? data16[15:8] : data16[7:0];

   // Same level launched on both edges
   assign frame_pin = frame;

   // Forwarded clock, quarter cycle late so the receiver samples mid-eye
   assign lclk_pin = tx_lclk90;

   // ######################################################################
   // Pin pairs
   // ######################################################################
   assign txo_data_p  = data_pin;
   assign txo_data_n  = ~data_pin;
   assign txo_frame_p = frame_pin;
   assign txo_frame_n = ~frame_pin;
   assign txo_lclk_p  = lclk_pin;
   assign txo_lclk_n  = ~lclk_pin;

endmodule

/* source/etx_wait_sync.sv */
`timescale 1ns/1ps

module etx_wait_sync
#(
   parameter int ETYPE = 0
)
(
   input  logic tx_lclk,
   input  logic reset,
   // Pushback pins from the remote side
   input  logic txi_wr_wait_p,
   input  logic txi_wr_wait_n,
   input  logic txi_rd_wait_p,
   input  logic txi_rd_wait_n,
   output logic tx_wr_wait,
   output logic tx_rd_wait
);

   // Bit 0 write wait, bit 1 read wait
   logic [1:0] wait_p;
   logic [1:0] wait_n;
   logic [1:0] wait_pin;
   logic [1:0] wait_meta;
   logic [1:0] wait_sync;

   assign wait_p = {txi_rd_wait_p, txi_wr_wait_p};
   assign wait_n = {txi_rd_wait_n, txi_wr_wait_n};

   // Pin receiver
   generate
      if (ETYPE == 0)
      begin : g_diff
         // Asserted only when the pair disagrees the right way
         assign wait_pin = wait_p & ~wait_n;
      end
      else
      begin : g_single
         // Single-ended board, n pin left floating
         assign wait_pin = wait_p;
      end
   endgenerate

   // Two-flop synchronizer into tx_lclk
   always_ff @(posedge tx_lclk)
   begin
      if (reset)
      begin
         wait_meta <= '0;
         wait_sync <= '0;
      end
      else
      begin
         wait_meta <= wait_pin;
         wait_sync <= wait_meta;
      end
   end

   assign tx_wr_wait = wait_sync[0];
   assign tx_rd_wait = wait_sync[1];

endmodule

/* source/etx_top.sv */
`timescale 1ns/1ps

module etx_top
   import elink_pkg::*;
#(
   parameter int PW    = PW_DEFAULT,
   parameter int DEPTH = 4,
   // 0 differential wait pins, 1 single-ended
   parameter int ETYPE = 0
)
(
   input  logic          reset,
   input  logic          tx_lclk,
   input  logic          tx_lclk90,
   // Fabric side
   input  logic [PW-1:0] tx_packet,
   input  logic          tx_access,
   output logic          tx_full,
   output logic          tx_io_wait,
   output logic          tx_wr_wait,
   output logic          tx_rd_wait,
   // Link pins
   output logic [7:0]    txo_data_p,
   output logic [7:0]    txo_data_n,
   output logic          txo_frame_p,
   output logic          txo_frame_n,
   output logic          txo_lclk_p,
   output logic          txo_lclk_n,
   input  logic          txi_wr_wait_p,
   input  logic          txi_wr_wait_n,
   input  logic          txi_rd_wait_p,
   input  logic          txi_rd_wait_n
);

   // Queue head toward the FSM
   logic        pkt_valid;
   logic        pkt_pop;
   logic        pkt_burst;
   logic        pkt_write;
   logic [1:0]  pkt_datamode;
   logic [3:0]  pkt_ctrlmode;
   logic [31:0] pkt_dstaddr;
   logic [31:0] pkt_data;
   logic [31:0] pkt_srcaddr;
   // Beats toward the pins
   logic [15:0] data16;
   logic        frame;

   // ######################################################################
   // Packet queue and transmit FSM
   // ######################################################################
   etx_packet_queue #(
      .PW    (PW),
      .DEPTH (DEPTH)
   ) etx_packet_queue_inst (
      .tx_lclk      (tx_lclk),
      .reset        (reset),
      .tx_packet    (tx_packet),
      .tx_access    (tx_access),
      .tx_full      (tx_full),
      .pkt_pop      (pkt_pop),
      .pkt_valid    (pkt_valid),
      .pkt_write    (pkt_write),
      .pkt_datamode (pkt_datamode),
      .pkt_ctrlmode (pkt_ctrlmode),
      .pkt_dstaddr  (pkt_dstaddr),
      .pkt_data     (pkt_data),
      .pkt_srcaddr  (pkt_srcaddr),
      .pkt_burst    (pkt_burst)
   );

   etx_io #(
      .PW (PW)
   ) etx_io_inst (
      .tx_lclk      (tx_lclk),
      .reset        (reset),
      .pkt_valid    (pkt_valid),
      .pkt_burst    (pkt_burst),
      .pkt_write    (pkt_write),
      .pkt_datamode (pkt_datamode),
      .pkt_ctrlmode (pkt_ctrlmode),
      .pkt_dstaddr  (pkt_dstaddr),
      .pkt_data     (pkt_data),
      .pkt_srcaddr  (pkt_srcaddr),
      .pkt_pop      (pkt_pop),
      .data16       (data16),
      .frame        (frame),
      .tx_io_wait   (tx_io_wait)
   );

   // ######################################################################
   // Pin stages
   // ######################################################################
   etx_ddr_out etx_ddr_out_inst (
      .tx_lclk     (tx_lclk),
      .tx_lclk90   (tx_lclk90),
      .data16      (data16),
      .frame       (frame),
      .txo_data_p  (txo_data_p),
      .txo_data_n  (txo_data_n),
      .txo_frame_p (txo_frame_p),
      .txo_frame_n (txo_frame_n),
      .txo_lclk_p  (txo_lclk_p),
      .txo_lclk_n  (txo_lclk_n)
   );

   etx_wait_sync #(
      .ETYPE (ETYPE)
   ) etx_wait_sync_inst (
      .tx_lclk       (tx_lclk),
      .reset         (reset),
      .txi_wr_wait_p (txi_wr_wait_p),
      .txi_wr_wait_n (txi_wr_wait_n),
      .txi_rd_wait_p (txi_rd_wait_p),
      .txi_rd_wait_n (txi_rd_wait_n),
      .tx_wr_wait    (tx_wr_wait),
      .tx_rd_wait    (tx_rd_wait)
   );

endmodule

/* include/etx_tb_defs.svh */
`ifndef ETX_TB_DEFS_SVH
`define ETX_TB_DEFS_SVH

// Stimulus volume
`define ETX_TB_NUM_PACKETS    200
// Depth of the expected-packet queue in the receiver model
`define ETX_TB_MODEL_DEPTH    64
// tx_lclk period and the quarter-cycle shift of tx_lclk90, in ns
`define ETX_TB_CLK_PERIOD     100
`define ETX_TB_CLK90_DELAY    25
// Drive point after each rising edge, in ns
`define ETX_TB_INPUT_SKEW     10
`define ETX_TB_RESET_CYCLES   5
`define ETX_TB_LFSR_SEED      32'h3d4a

`endif

/* testbench/etx_tb_model.sv */
`timescale 1ns/1ps
`include "etx_tb_defs.svh"

module etx_tb_model
   import elink_pkg::*;
#(
   parameter int PW = 104
)
(
   input  logic          tx_lclk,
   input  logic          reset,
   // Fabric strobe, copied into the expected queue
   input  logic [PW-1:0] tx_packet,
   input  logic          tx_access,
   // Link pins
   input  logic [7:0]    txo_data_p,
   input  logic [7:0]    txo_data_n,
   input  logic          txo_frame_p,
   input  logic          txo_frame_n,
   input  logic          txo_lclk_p,
   // Progress and error counts for the top
   output int            rx_count,
   output int            err_count
);

   logic [PW-1:0] exp_q [$];
   logic [PW-1:0] prev_pkt;
   logic [7:0]    upper;
   logic [47:0]   hdr_rx;
   logic [63:0]   pld_rx;
   // Beat slot in the current packet, 0 to 2 header, 3 to 6 payload
   int            pos;
   logic          has_hdr;
   logic          in_frame;
   logic          at_boundary;

   initial
   begin
      rx_count    = 0;
      err_count   = 0;
      pos         = 0;
      has_hdr     = 1'b0;
      in_frame    = 1'b0;
      at_boundary = 1'b0;
      prev_pkt    = '0;
   end

   task automatic flag_mismatch(input string name, input logic [63:0] got,
                                input logic [63:0] want);
      err_count++;
      $display("FAILED %s at %0t: got %h, expected %h", name, $time, got, want);
   endtask

   task automatic flag_event(input string msg);
      err_count++;
      $display("ERROR at %0t: %s", $time, msg);
   endtask

   task automatic check_pair(input string name, input logic [7:0] p, input logic [7:0] n);
      logic [7:0] want;
      want = ~p;
      assert (n == want) else flag_mismatch(name, n, want);
   endtask

   // Double writes, same ctrlmode, address stepping by 8
   function automatic logic burst_ok(input logic [PW-1:0] first, input logic [PW-1:0] second);
      return first[PKT_WRITE_BIT] && second[PKT_WRITE_BIT]
         && (first[PKT_DATAMODE_LSB +: 2] == 2'd3)
         && (second[PKT_DATAMODE_LSB +: 2] == 2'd3)
         && (first[PKT_CTRLMODE_LSB +: 4] == second[PKT_CTRLMODE_LSB +: 4])
         && (second[PKT_DSTADDR_LSB +: 32] == first[PKT_DSTADDR_LSB +: 32] + 32'd8);
   endfunction

   // ######################################################################
   // Packet compare
   // ######################################################################
   task automatic check_packet();
      logic [PW-1:0] exp;
      logic [47:0]   want_hdr;
      logic [63:0]   want_pld;
      logic          w;
      if (exp_q.size() == 0)
      begin
         flag_event("packet on the pins with no packet expected");
         return;
      end
      exp     = exp_q.pop_front();
      w       = exp[PKT_WRITE_BIT];
      if (has_hdr)
      begin
         // Inverted write, zeros, ctrlmode, dstaddr, datamode, write, access
         want_hdr = {~w, 7'd0, exp[PKT_CTRLMODE_LSB +: 4], exp[PKT_DSTADDR_LSB +: 32],
                     exp[PKT_DATAMODE_LSB +: 2], w, 1'b1};
         assert (hdr_rx == want_hdr) else flag_mismatch("header beats", hdr_rx, want_hdr);
      end
      else
      begin
         // Continuation only allowed when the pair forms a burst
         assert (burst_ok(prev_pkt, exp))
         else flag_event($sformatf("packet %0d continues a frame without burst rules",
                                   rx_count));
      end
      want_pld = {exp[PKT_DATA_LSB +: 32], exp[PKT_SRCADDR_LSB +: 32]};
      assert (pld_rx == want_pld) else flag_mismatch("payload beats", pld_rx, want_pld);
      prev_pkt = exp;
      rx_count++;
   endtask

   task automatic take_beat(input logic [15:0] beat);
      if (pos < 3)
      begin
         hdr_rx[47 - 16 * pos -: 16] = beat;
      end
      else
      begin
         pld_rx[63 - 16 * (pos - 3) -: 16] = beat;
      end
      at_boundary = 1'b0;
      if (pos == 6)
      begin
         check_packet();
         // Next packet in the same frame has no header
         pos         = 3;
         has_hdr     = 1'b0;
         at_boundary = 1'b1;
      end
      else
      begin
         pos++;
      end
   endtask

   // ######################################################################
   // Expected queue and pin sampling
   // ######################################################################
   always @(posedge tx_lclk)
   begin
      if (!reset && tx_access)
      begin
         if (exp_q.size() >= `ETX_TB_MODEL_DEPTH)
         begin
            flag_event("expected packet queue overflow");
         end
         exp_q.push_back(tx_packet);
      end
   end

   // Upper byte mid high phase
   always @(posedge txo_lclk_p)
   begin
      if (reset)
      begin
         in_frame = 1'b0;
      end
      else
      begin
         check_pair("txo_data_n", txo_data_p, txo_data_n);
         assert (txo_frame_n == !txo_frame_p)
         else flag_mismatch("txo_frame_n", txo_frame_n, !txo_frame_p);
         if (txo_frame_p)
         begin
            if (!in_frame)
            begin
               // Fresh frame opens with a header
               in_frame    = 1'b1;
               has_hdr     = 1'b1;
               pos         = 0;
               at_boundary = 1'b0;
            end
            upper = txo_data_p;
         end
         else
         begin
            if (in_frame && !at_boundary)
            begin
               flag_event("frame dropped inside a packet");
            end
            in_frame = 1'b0;
            // Idle pins stay low
            assert (txo_data_p == 8'd0) else flag_mismatch("txo_data_p", txo_data_p, 0);
         end
      end
   end

   // Lower byte mid low phase closes the beat
   always @(negedge txo_lclk_p)
   begin
      if (!reset)
      begin
         check_pair("txo_data_n", txo_data_p, txo_data_n);
         if (txo_frame_p && in_frame)
         begin
            take_beat({upper, txo_data_p});
         end
         else if (!txo_frame_p)
         begin
            assert (txo_data_p == 8'd0) else flag_mismatch("txo_data_p", txo_data_p, 0);
         end
      end
   end

endmodule

/* testbench/etx_tb.sv */
`timescale 1ns/1ps
`include "etx_tb_defs.svh"

module etx_tb
   import elink_pkg::*;
();

   localparam int     PW    = 104;
   localparam int     DEPTH = 4;
   localparam int     ETYPE = 0;
   localparam int     NUM   = `ETX_TB_NUM_PACKETS;
   // Worst case per packet plus slack for reset and drain
   localparam longint WATCHDOG_NS = longint'(NUM * 12 + 200) * `ETX_TB_CLK_PERIOD;

   logic          reset;
   logic          tx_lclk;
   wire           tx_lclk90;
   logic [PW-1:0] tx_packet;
   logic          tx_access;
   logic          tx_full;
   logic          tx_io_wait;
   logic          tx_wr_wait;
   logic          tx_rd_wait;
   logic [7:0]    txo_data_p;
   logic [7:0]    txo_data_n;
   logic          txo_frame_p;
   logic          txo_frame_n;
   logic          txo_lclk_p;
   logic          txo_lclk_n;
   logic          txi_wr_wait_p;
   logic          txi_wr_wait_n;
   logic          txi_rd_wait_p;
   logic          txi_rd_wait_n;

   // Stimulus state
   logic [31:0]   lfsr_state;
   logic [PW-1:0] last_pkt;
   // Expected wait levels, bit 1 is two cycles old
   logic [1:0]    wr_hist;
   logic [1:0]    rd_hist;
   // Frame pin and tx_io_wait per cycle, bit 0 is the current cycle
   logic [5:0]    frame_hist;
   logic [5:0]    io_wait_hist;
   int            pushed;
   int            errors;
   int            rx_count;
   int            model_errors;

   // ######################################################################
   // Clocks, DUT and receiver model
   // ######################################################################
   initial tx_lclk = 1'b0;
   always #(`ETX_TB_CLK_PERIOD / 2) tx_lclk = ~tx_lclk;

   // Quarter cycle late copy
   assign #(`ETX_TB_CLK90_DELAY) tx_lclk90 = tx_lclk;

   etx_top #(
      .PW    (PW),
      .DEPTH (DEPTH),
      .ETYPE (ETYPE)
   ) etx_top_inst (
      .reset         (reset),
      .tx_lclk       (tx_lclk),
      .tx_lclk90     (tx_lclk90),
      .tx_packet     (tx_packet),
      .tx_access     (tx_access),
      .tx_full       (tx_full),
      .tx_io_wait    (tx_io_wait),
      .tx_wr_wait    (tx_wr_wait),
      .tx_rd_wait    (tx_rd_wait),
      .txo_data_p    (txo_data_p),
      .txo_data_n    (txo_data_n),
      .txo_frame_p   (txo_frame_p),
      .txo_frame_n   (txo_frame_n),
      .txo_lclk_p    (txo_lclk_p),
      .txo_lclk_n    (txo_lclk_n),
      .txi_wr_wait_p (txi_wr_wait_p),
      .txi_wr_wait_n (txi_wr_wait_n),
      .txi_rd_wait_p (txi_rd_wait_p),
      .txi_rd_wait_n (txi_rd_wait_n)
   );

   etx_tb_model #(
      .PW (PW)
   ) etx_tb_model_inst (
      .tx_lclk     (tx_lclk),
      .reset       (reset),
      .tx_packet   (tx_packet),
      .tx_access   (tx_access),
      .txo_data_p  (txo_data_p),
      .txo_data_n  (txo_data_n),
      .txo_frame_p (txo_frame_p),
      .txo_frame_n (txo_frame_n),
      .txo_lclk_p  (txo_lclk_p),
      .rx_count    (rx_count),
      .err_count   (model_errors)
   );

   // ######################################################################
   // Random source and packet builder
   // ######################################################################

   // Galois form, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // One LFSR step per bit
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] bits;
      bits = '0;
      for (int i = 0; i < n; i++)
      begin
         bits       = {bits[30:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
      return bits;
   endfunction

   // Kind 0-1 random, 2 burst start, 3-6 continuation, 7 near miss
   function automatic logic [PW-1:0] make_packet(input logic [PW-1:0] prev);
      logic [PW-1:0] pkt;
      logic [2:0]    kind;
      logic          write;
      logic [1:0]    datamode;
      logic [3:0]    ctrlmode;
      logic [31:0]   dstaddr;
      kind     = 3'(take_bits(3));
      write    = 1'(take_bits(1));
      datamode = 2'(take_bits(2));
      ctrlmode = 4'(take_bits(4));
      dstaddr  = take_bits(32);
      if (kind >= 3'd2)
      begin
         write    = 1'b1;
         datamode = DATAMODE_DOUBLE;
      end
      if (kind >= 3'd3)
      begin
         ctrlmode = prev[PKT_CTRLMODE_LSB +: 4];
         dstaddr  = prev[PKT_DSTADDR_LSB +: 32] + 32'd8;
      end
      if (kind == 3'd7)
      begin
         // Break one burst rule
         if (take_bits(1) != 0)
         begin
            ctrlmode = ctrlmode ^ 4'd1;
         end
         else
         begin
            dstaddr = dstaddr + 32'd8;
         end
      end
      pkt                           = '0;
      pkt[PKT_WRITE_BIT]            = write;
      pkt[PKT_DATAMODE_LSB +: 2]    = datamode;
      pkt[PKT_CTRLMODE_LSB +: 4]    = ctrlmode;
      pkt[PKT_DSTADDR_LSB +: 32]    = dstaddr;
      pkt[PKT_DATA_LSB +: 32]       = take_bits(32);
      pkt[PKT_SRCADDR_LSB +: 32]    = take_bits(32);
      return pkt;
   endfunction

   // Pin pair {p, n}, a quarter asserted, a quarter agreeing
   function automatic logic [1:0] wait_pins(input logic [2:0] code);
      case (code)
         3'd0    : return 2'b11;
         3'd1    : return 2'b00;
         3'd2,
         3'd3    : return 2'b10;
         default : return 2'b01;
      endcase
   endfunction

   task automatic flag_mismatch(input string name, input logic [63:0] got,
                                input logic [63:0] want);
      errors++;
      $display("FAILED %s at %0t: got %h, expected %h", name, $time, got, want);
   endtask

   // ######################################################################
   // Per-cycle drive and checks
   // ######################################################################
   task automatic drive_cycle();
      logic [1:0] gap;
      logic       io_wait_want;
      // Sync output lags the pins by two edges
      assert (tx_wr_wait == wr_hist[1]) else flag_mismatch("tx_wr_wait", tx_wr_wait, wr_hist[1]);
      assert (tx_rd_wait == rd_hist[1]) else flag_mismatch("tx_rd_wait", tx_rd_wait, rd_hist[1]);
      assert (txo_lclk_n == !txo_lclk_p) else flag_mismatch("txo_lclk_n", txo_lclk_n, !txo_lclk_p);
      // Last packet of a frame holds tx_io_wait from CYCLE4 to CYCLE7,
      // the three cycles that end three cycles before frame falls
      frame_hist   = {frame_hist[4:0], txo_frame_p};
      io_wait_hist = {io_wait_hist[4:0], tx_io_wait};
      io_wait_want = (frame_hist[3] & ~frame_hist[2])
                   | (frame_hist[2] & ~frame_hist[1])
                   | (frame_hist[1] & ~frame_hist[0]);
      assert (io_wait_hist[5] == io_wait_want)
      else flag_mismatch("tx_io_wait", io_wait_hist[5], io_wait_want);
      {txi_wr_wait_p, txi_wr_wait_n} = wait_pins(3'(take_bits(3)));
      {txi_rd_wait_p, txi_rd_wait_n} = wait_pins(3'(take_bits(3)));
      wr_hist = {wr_hist[0], txi_wr_wait_p & ~txi_wr_wait_n};
      rd_hist = {rd_hist[0], txi_rd_wait_p & ~txi_rd_wait_n};
      // Fabric holds off on full or write wait
      gap = 2'(take_bits(2));
      if ((pushed < NUM) && !tx_full && !tx_wr_wait && (gap != 2'd0))
      begin
         last_pkt  = make_packet(last_pkt);
         tx_packet = last_pkt;
         tx_access = 1'b1;
         pushed++;
      end
      else
      begin
         tx_access = 1'b0;
      end
   endtask

   initial
   begin
      reset         = 1'b1;
      tx_packet     = '0;
      tx_access     = 1'b0;
      txi_wr_wait_p = 1'b0;
      txi_wr_wait_n = 1'b1;
      txi_rd_wait_p = 1'b0;
      txi_rd_wait_n = 1'b1;
      lfsr_state    = `ETX_TB_LFSR_SEED;
      last_pkt      = '0;
      wr_hist       = '0;
      rd_hist       = '0;
      frame_hist    = '0;
      io_wait_hist  = '0;
      pushed        = 0;
      errors        = 0;
      repeat (`ETX_TB_RESET_CYCLES) @(posedge tx_lclk);
      #(`ETX_TB_INPUT_SKEW);
      reset = 1'b0;
      assert (!tx_full && !tx_io_wait)
      else
      begin
         errors++;
         $display("ERROR at %0t: tx_full or tx_io_wait high after reset", $time);
      end
      // Push phase, then drain until every packet is back
      while ((pushed < NUM) || (rx_count < NUM))
      begin
         @(posedge tx_lclk);
         #(`ETX_TB_INPUT_SKEW);
         drive_cycle();
      end
      // Quiet tail, nothing extra may appear
      repeat (20)
      begin
         @(posedge tx_lclk);
         #(`ETX_TB_INPUT_SKEW);
         drive_cycle();
      end
      $display("pushed %0d, received %0d, testbench errors %0d, model errors %0d",
               pushed, rx_count, errors, model_errors);
      if ((errors + model_errors) == 0)
      begin
         $display("sim passed");
      end
      else
      begin
         $display("sim failed");
      end
      $finish;
   end

   // Watchdog
   initial
   begin
      #(WATCHDOG_NS);
      $display("ERROR: run timed out with %0d of %0d packets received", rx_count, NUM);
      $display("sim failed");
      $finish;
   end

endmodule

/* Bender.yml */
package:
  name: etx

sources:
  # Package first, then the RTL bottom up
  - source/elink_pkg.sv
  - source/etx_packet_queue.sv
  - source/etx_io.sv
  - source/etx_ddr_out.sv
  - source/etx_wait_sync.sv
  - source/etx_top.sv

  # Testbench, receiver model before the top module
  - target: test
    include_dirs:
      - include
    files:
      - testbench/etx_tb_model.sv
      - testbench/etx_tb.sv

/* sim.f */
+incdir+include
source/elink_pkg.sv
source/etx_packet_queue.sv
source/etx_io.sv
source/etx_ddr_out.sv
source/etx_wait_sync.sv
source/etx_top.sv
testbench/etx_tb_model.sv
testbench/etx_tb.sv
